//--- Bender.yml
package:
  name: rrb

sources:
  - files:
      - rtl/rrb_pkg.sv
      - rtl/find_first_set.sv
      - rtl/read_return_buffer.sv
      - rtl/read_issue.sv
      - rtl/return_ram.sv
      - rtl/rrb_top.sv
  - target: simulation
    files:
      - dv/rrb_checker.sv
      - dv/rrb_tb.sv

//--- dv/rrb_checker.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks bound into the return buffer
module rrb_checker (
  input wire logic clk,
  input wire logic rst,
  input wire logic in_en,
  input wire logic out_ready,
  input wire logic pause,
  input wire logic out_strobe,
  input wire logic any_free
);

  // count of failed assertions
  int unsigned fail_cnt = 0;

  // words parked in slots as counted from reads and strobes
  logic [rrb_pkg::free_w-1:0] held;

  always_ff @(posedge clk) begin
    if (rst) begin
      held <= '0;
    end else begin
      held <= held + {{(rrb_pkg::free_w - 1){1'b0}}, in_en}
                    - {{(rrb_pkg::free_w - 1){1'b0}}, out_strobe};
    end
  end

  // issuer must hold off while paused
  a_no_read_in_pause: assert property (@(posedge clk) disable iff (rst) !(in_en && pause))
    else begin
      fail_cnt++;
      $error("read issued while pause high");
    end

  // a paused buffer still keeps one slot for the read in flight
  a_pause_keeps_spare: assert property (@(posedge clk) disable iff (rst) pause |-> any_free)
    else begin
      fail_cnt++;
      $error("pause high with no slot left");
    end

  // each strobe delivers a read from this cycle or a parked word
  a_strobe_has_word: assert property (@(posedge clk) disable iff (rst)
    out_strobe |-> (in_en || held != '0))
    else begin
      fail_cnt++;
      $error("strobe with no word to deliver");
    end

  // every read either bypasses or finds a slot
  a_read_has_room: assert property (@(posedge clk) disable iff (rst) in_en |-> any_free)
    else begin
      fail_cnt++;
      $error("read arrived with no free slot");
    end

  // quiet outputs right after reset
  a_reset_quiet: assert property (@(posedge clk) rst |=> !pause && !out_strobe && !in_en)
    else begin
      fail_cnt++;
      $error("outputs active after reset");
    end

endmodule

`default_nettype wire

//--- dv/rrb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rrb_tb;

  logic                       clk;
  logic                       rst;
  logic                       start;
  logic                       wr_en;
  logic [rrb_pkg::tag_w-1:0]  wr_addr;
  logic [rrb_pkg::data_w-1:0] wr_data;
  logic                       out_ready;
  logic                       done;
  logic                       pause;
  logic                       out_strobe;
  logic [rrb_pkg::data_w-1:0] out_data;

  // scoreboard
  int unsigned seen [rrb_pkg::num_reads];
  int unsigned deliver_cnt;
  int unsigned err_value;
  int unsigned err_other;
  logic [rrb_pkg::tag_w-1:0] next_tag;
  logic order_check;
  logic bypass_check;
  logic saw_pause;
  logic [rrb_pkg::read_lat-1:0] pend;

  // random consumer stretches
  logic [31:0] rng;
  int unsigned stretch_left;
  logic        stretch_lvl;

  rrb_top dut (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .out_ready (out_ready),
    .done      (done),
    .pause     (pause),
    .out_strobe(out_strobe),
    .out_data  (out_data)
  );

  bind read_return_buffer rrb_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .in_en     (in_en),
    .out_ready (out_ready),
    .pause     (pause),
    .out_strobe(out_strobe),
    .any_free  (any_free)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // low 24 bits of each stored word scrambled from the address
  function automatic logic [23:0] mix24(input logic [rrb_pkg::tag_w-1:0] a);
    logic [31:0] x;
    x = ({24'h0, a} + 32'h5a3) * 32'h9e3779b1;
    x = x ^ (x >> 15);
    return x[23:0] ^ {a, ~a, a};
  endfunction

  // reference word with the address on top and the mix below
  function automatic logic [rrb_pkg::data_w-1:0] expected_word(
    input logic [rrb_pkg::tag_w-1:0] tag);
    return {tag, mix24(tag)};
  endfunction

  task automatic compare_word(input string name, input logic [rrb_pkg::data_w-1:0] got,
                              input logic [rrb_pkg::data_w-1:0] exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      err_value++;
    end
  endtask

  task automatic verify_tag(input string name, input logic [rrb_pkg::tag_w-1:0] got,
                            input logic [rrb_pkg::tag_w-1:0] exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      err_value++;
    end
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      err_value++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic record_delivery(input logic [rrb_pkg::data_w-1:0] word);
    logic [rrb_pkg::tag_w-1:0] tag;
    tag = word[rrb_pkg::data_w-1 -: rrb_pkg::tag_w];
    // integrity of the low bits against the tag it claims
    compare_word("out_data", word, expected_word(tag));
    if (tag >= rrb_pkg::num_reads) begin
      $display("delivered tag %0d was never read", tag);
      err_other++;
    end else begin
      seen[tag]++;
    end
    if (order_check) begin
      verify_tag("out_data tag", tag, next_tag);
      next_tag++;
    end
    deliver_cnt++;
  endtask

  // compare process samples 1 ns after the falling edge
  always begin
    @(negedge clk);
    #1;
    if (rst) begin
      pend = '0;
    end else begin
      // word for a strobe shows read_lat cycles later
      if (pend[rrb_pkg::read_lat-1])
        record_delivery(out_data);
      pend = {pend[rrb_pkg::read_lat-2:0], out_strobe};
      if (pause)
        saw_pause = 1'b1;
      if (pause && dut.rd_en) begin
        $display("read issued while pause was high");
        err_other++;
      end
      // in pure bypass the strobe lines up with its read
      if (bypass_check)
        expect_bit("out_strobe", out_strobe, dut.rd_en);
    end
  end

  task automatic clear_scoreboard();
    foreach (seen[i])
      seen[i] = 0;
    deliver_cnt = 0;
    next_tag = '0;
    saw_pause = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    start = 1'b0;
    out_ready = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic preload_ram();
    for (int a = 0; a < 2**rrb_pkg::tag_w; a++) begin
      @(negedge clk);
      wr_en = 1'b1;
      wr_addr = rrb_pkg::tag_w'(a);
      wr_data = expected_word(rrb_pkg::tag_w'(a));
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic pulse_start();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  // one cycle of random ready in stretches of 1 to 16
  task automatic step_ready();
    if (stretch_left == 0) begin
      rng = lcg_next(rng);
      stretch_lvl = rng[16];
      stretch_left = 1 + rng[22:19];
    end
    out_ready = stretch_lvl;
    stretch_left--;
  endtask

  // idle after reset without start keeps everything low
  task automatic idle_quiet(input int unsigned n);
    repeat (n) begin
      @(negedge clk);
      step_ready();
      #1;
      expect_bit("pause", pause, 1'b0);
      expect_bit("out_strobe", out_strobe, 1'b0);
      expect_bit("rd_en", dut.rd_en, 1'b0);
      expect_bit("done", done, 1'b0);
    end
  endtask

  task automatic run_until_done(input logic random_ready);
    int unsigned cyc;
    cyc = 0;
    while (!done) begin
      if (cyc >= 4000)
        abort_run("done did not rise within 4000 cycles");
      @(negedge clk);
      if (random_ready)
        step_ready();
      cyc++;
    end
  endtask

  task automatic drain_outputs();
    int unsigned cyc;
    cyc = 0;
    @(negedge clk);
    out_ready = 1'b1;
    while (deliver_cnt < rrb_pkg::num_reads) begin
      if (cyc >= 200)
        abort_run("buffer did not deliver every word within 200 cycles");
      @(negedge clk);
      cyc++;
    end
    // window for stray strobes
    repeat (8) @(negedge clk);
    if (deliver_cnt != rrb_pkg::num_reads) begin
      $display("%0d words delivered, %0d expected", deliver_cnt, rrb_pkg::num_reads);
      err_other++;
    end
    foreach (seen[t]) begin
      if (seen[t] != 1) begin
        $display("tag %0d delivered %0d times", t, seen[t]);
        err_other++;
      end
    end
  endtask

  initial begin
    int unsigned total;
    rst = 1'b1;
    start = 1'b0;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    out_ready = 1'b0;
    rng = 32'd11946;
    stretch_left = 0;
    stretch_lvl = 1'b0;
    err_value = 0;
    err_other = 0;
    order_check = 1'b0;
    bypass_check = 1'b0;
    pend = '0;
    clear_scoreboard();
    apply_reset();
    idle_quiet(16);
    preload_ram();

    // consumer always ready so words come in address order
    clear_scoreboard();
    out_ready = 1'b1;
    order_check = 1'b1;
    bypass_check = 1'b1;
    pulse_start();
    run_until_done(1'b0);
    drain_outputs();
    order_check = 1'b0;
    bypass_check = 1'b0;

    // back-pressure from long random stalls
    apply_reset();
    clear_scoreboard();
    pulse_start();
    run_until_done(1'b1);
    drain_outputs();
    if (!saw_pause) begin
      $display("pause never rose under back-pressure");
      err_other++;
    end

    // reset mid-run and then a full second run
    apply_reset();
    pulse_start();
    repeat (20) begin
      @(negedge clk);
      step_ready();
    end
    apply_reset();
    idle_quiet(12);
    clear_scoreboard();
    pulse_start();
    run_until_done(1'b1);
    drain_outputs();

    total = err_value + err_other + dut.u_buf.u_checker.fail_cnt;
    $display("errors: %0d value, %0d protocol, %0d assertion",
             err_value, err_other, dut.u_buf.u_checker.fail_cnt);
    if (total == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
rtl/rrb_pkg.sv
rtl/find_first_set.sv
rtl/read_return_buffer.sv
rtl/read_issue.sv
rtl/return_ram.sv
rtl/rrb_top.sv
dv/rrb_checker.sv
dv/rrb_tb.sv

//--- rtl/find_first_set.sv
`timescale 1ns/1ps
`default_nettype none

// lowest set bit as one-hot, plus an any-set flag
module find_first_set #(
  parameter int unsigned width = 4
) (
  input  wire logic [width-1:0] bits,
  output logic      [width-1:0] first,
  output logic                  any
);

  logic found;

  always_comb begin
    first = '0;
    found = 1'b0;
    // scan upward, first hit wins
    for (int i = 0; i < width; i++) begin
      if (bits[i] && !found) begin
        first[i] = 1'b1;
        found    = 1'b1;
      end
    end
  end

  assign any = found;

endmodule

`default_nettype wire

//--- rtl/read_issue.sv
`timescale 1ns/1ps
`default_nettype none

// issues num_reads sequential reads, holds off while paused
module read_issue (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      start,
  input  wire logic                      pause,
  output logic                           rd_en,
  output logic      [rrb_pkg::tag_w-1:0] rd_addr,
  output logic                           done
);

  rrb_pkg::issue_state_e state;
  rrb_pkg::issue_state_e state_nxt;

  // one read per unpaused cycle in run
  assign rd_en = (state == rrb_pkg::st_run) && !pause;

  // done is held until reset
  assign done = (state == rrb_pkg::st_done);

  always_comb begin
    state_nxt = state;
    case (state)
      rrb_pkg::st_idle: begin
        if (start) begin
          state_nxt = rrb_pkg::st_run;
        end
      end
      rrb_pkg::st_run: begin
        // last address just went out
        if (rd_en && (rd_addr == rrb_pkg::last_rd_addr)) begin
          state_nxt = rrb_pkg::st_done;
        end
      end
      rrb_pkg::st_done: begin
        state_nxt = rrb_pkg::st_done;
      end
      default: begin
        state_nxt = rrb_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rrb_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // address counter, restarts at zero on start
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr <= '0;
    end else if (state == rrb_pkg::st_idle && start) begin
      rd_addr <= '0;
    end else if (rd_en) begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/read_return_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// holding buffer for returned words
// empty and ready: word bypasses straight to out_data
// otherwise it parks in a slot, lowest occupied slot drains first
module read_return_buffer (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       in_en,
  input  wire logic [rrb_pkg::data_w-1:0] d_in,
  input  wire logic                       out_ready,
  output logic                            pause,
  output logic                            out_strobe,
  output logic      [rrb_pkg::data_w-1:0] out_data
);

  // one bit per slot, set when slot is free
  logic [rrb_pkg::slot_cnt-1:0] free_mask;

  // slot payload, written read_lat cycles after claim
  logic [rrb_pkg::data_w-1:0] slot_data [rrb_pkg::slot_cnt];

  logic [rrb_pkg::slot_cnt-1:0] first_free;
  logic                         any_free;
  logic [rrb_pkg::slot_cnt-1:0] first_occ;
  logic                         any_occ;

  logic [rrb_pkg::free_w-1:0] free_cnt;

  logic claim;
  logic deliver;

  // per-slot write enable, delayed to meet returning data
  logic [rrb_pkg::slot_cnt-1:0] wen_pipe [rrb_pkg::read_lat];
  // selected slot and its valid, delayed to meet the output
  logic [rrb_pkg::slot_cnt-1:0] sel_pipe [rrb_pkg::read_lat];
  logic [rrb_pkg::read_lat-1:0] sel_vld_pipe;

  find_first_set #(
    .width(rrb_pkg::slot_cnt)
  ) u_ffs_free (
    .bits (free_mask),
    .first(first_free),
    .any  (any_free)
  );

  find_first_set #(
    .width(rrb_pkg::slot_cnt)
  ) u_ffs_occ (
    .bits (~free_mask),
    .first(first_occ),
    .any  (any_occ)
  );

  // popcount of free slots
  always_comb begin
    free_cnt = '0;
    for (int i = 0; i < rrb_pkg::slot_cnt; i++) begin
      free_cnt = free_cnt + {{(rrb_pkg::free_w - 1){1'b0}}, free_mask[i]};
    end
  end

  // stall the issuer while the consumer is away and room is short
  assign pause = !out_ready && (free_cnt < rrb_pkg::pause_margin);

  // drain oldest-indexed slot when consumer is ready
  assign deliver = out_ready && any_occ;

  // park the word unless it can bypass
  assign claim = in_en && any_free && (!out_ready || any_occ);

  // one strobe per cycle, either bypass or slot drain
  assign out_strobe = out_ready && (in_en || any_occ);

  always_ff @(posedge clk) begin
    if (rst) begin
      free_mask <= '1;
    end else begin
      // freed slot is not reclaimable in the same cycle
      free_mask <= (free_mask & ~(claim ? first_free : '0))
                 | (deliver ? first_occ : '0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < rrb_pkg::read_lat; s++) begin
        wen_pipe[s] <= '0;
        sel_pipe[s] <= '0;
      end
      sel_vld_pipe <= '0;
    end else begin
      wen_pipe[0]     <= claim ? first_free : '0;
      sel_pipe[0]     <= first_occ;
      sel_vld_pipe[0] <= deliver;
      for (int s = 1; s < rrb_pkg::read_lat; s++) begin
        wen_pipe[s]     <= wen_pipe[s-1];
        sel_pipe[s]     <= sel_pipe[s-1];
        sel_vld_pipe[s] <= sel_vld_pipe[s-1];
      end
    end
  end

  // capture the returning word into its claimed slot
  always_ff @(posedge clk) begin
    for (int i = 0; i < rrb_pkg::slot_cnt; i++) begin
      if (wen_pipe[rrb_pkg::read_lat-1][i]) begin
        slot_data[i] <= d_in;
      end
    end
  end

  // slot select, else bypass
  always_comb begin
    out_data = d_in;
    if (sel_vld_pipe[rrb_pkg::read_lat-1]) begin
      for (int i = 0; i < rrb_pkg::slot_cnt; i++) begin
        if (sel_pipe[rrb_pkg::read_lat-1][i]) begin
          out_data = slot_data[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/return_ram.sv
`timescale 1ns/1ps
`default_nettype none

// word memory, sync write, two-register read path
module return_ram (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       wr_en,
  input  wire logic [rrb_pkg::tag_w-1:0]  wr_addr,
  input  wire logic [rrb_pkg::data_w-1:0] wr_data,
  input  wire logic                       rd_en,
  input  wire logic [rrb_pkg::tag_w-1:0]  rd_addr,
  output logic      [rrb_pkg::data_w-1:0] rd_data
);

  logic [rrb_pkg::data_w-1:0] mem [2**rrb_pkg::tag_w];

  // first read stage
  logic [rrb_pkg::tag_w-1:0] rd_addr_q;
  logic                      rd_en_q;

  // preload port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_addr_q <= rd_addr;
    end
  end

  // output register, word valid two cycles after rd_en
  always_ff @(posedge clk) begin
    if (rd_en_q) begin
      rd_data <= mem[rd_addr_q];
    end
  end

endmodule

`default_nettype wire

//--- rtl/rrb_pkg.sv
`default_nettype none

package rrb_pkg;

  // returned word width
  localparam int unsigned data_w = 32;

  // address width, also the tag in the top bits of each word
  localparam int unsigned tag_w = 8;

  // holding slots in the return buffer
  localparam int unsigned slot_cnt = 4;

  // memory latency, strobe to data
  localparam int unsigned read_lat = 2;

  // reads issued per start
  localparam int unsigned num_reads = 64;

  // free counter must hold 0..slot_cnt
  localparam int unsigned free_w = $clog2(slot_cnt + 1);

  // pause below this many free slots
  localparam logic [free_w-1:0] pause_margin = free_w'(2);

  // address of the final read in a run
  localparam logic [tag_w-1:0] last_rd_addr = tag_w'(num_reads - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } issue_state_e;

endpackage

`default_nettype wire

//--- rtl/rrb_top.sv
`timescale 1ns/1ps
`default_nettype none

// issue unit -> memory -> return buffer
module rrb_top (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic                       start,
  input  wire logic                       wr_en,
  input  wire logic [rrb_pkg::tag_w-1:0]  wr_addr,
  input  wire logic [rrb_pkg::data_w-1:0] wr_data,
  input  wire logic                       out_ready,
  output logic                            done,
  output logic                            pause,
  output logic                            out_strobe,
  output logic      [rrb_pkg::data_w-1:0] out_data
);

  // issue side
  logic                      rd_en;
  logic [rrb_pkg::tag_w-1:0] rd_addr;

  // memory return, read_lat after rd_en
  logic [rrb_pkg::data_w-1:0] rd_data;

  read_issue u_issue (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .pause  (pause),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .done   (done)
  );

  return_ram u_ram (
    .clk    (clk),
    .rst    (rst),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  // read strobe claims a slot, data follows read_lat later
  read_return_buffer u_buf (
    .clk       (clk),
    .rst       (rst),
    .in_en     (rd_en),
    .d_in      (rd_data),
    .out_ready (out_ready),
    .pause     (pause),
    .out_strobe(out_strobe),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire
